// File: hdl/spmm_data_pkg.sv
package spmm_data_pkg;

    // square matrices, DIM x DIM
    localparam int DIM = 16;
    localparam int LG_DIM = $clog2(DIM);

    // 8-bit wrapping integers
    localparam int ELEM_W = 8;

    typedef logic [ELEM_W-1:0] elem_t;

    // lane, column or row index
    typedef logic [LG_DIM-1:0] lane_t;

    // stream cycle in the upper half, lane in the lower half
    typedef struct packed {
        lane_t cycle;
        lane_t lane;
    } csr_pos_t;

    // row-end pointer, compared as one flat position
    // or split into cycle and lane for the split table
    typedef union packed {
        logic [2*LG_DIM-1:0] flat;
        csr_pos_t            pos;
    } csr_ptr_t;

endpackage

// File: hdl/spmm_ctrl_pkg.sv
package spmm_ctrl_pkg;

    // product register in front of the reducer
    localparam int MUL_LATENCY = 1;

    // one register per prefix-scan level
    localparam int SCAN_LATENCY = spmm_data_pkg::LG_DIM;

    // multiply, scan, then the segment subtraction register
    localparam int PE_LATENCY = MUL_LATENCY + SCAN_LATENCY + 1;

endpackage

// File: hdl/rhs_buffer.sv
`timescale 1ns/100ps

module rhs_buffer #(
    parameter int beat_rows = 4
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 rhs_start,
    input  spmm_data_pkg::elem_t rhs_data [beat_rows][spmm_data_pkg::DIM],
    input  logic                 rhs_release,
    output logic                 rhs_ready,
    output logic                 full,
    output spmm_data_pkg::elem_t columns [spmm_data_pkg::DIM][spmm_data_pkg::DIM]
);

    localparam int DIM = spmm_data_pkg::DIM;
    localparam int NUM_BEATS = DIM / beat_rows;
    localparam int CNT_W = (NUM_BEATS > 1) ? $clog2(NUM_BEATS) : 1;

    logic             loading;
    logic [CNT_W-1:0] beat_cnt;
    logic             write_beat;
    logic             last_beat;

    // beat 0 comes with the start pulse, the rest back to back
    assign write_beat = rhs_start | loading;
    assign last_beat = write_beat && (beat_cnt == CNT_W'(NUM_BEATS - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            loading <= 1'b0;
            beat_cnt <= '0;
            full <= 1'b0;
            rhs_ready <= 1'b0;
        end else begin
            loading <= write_beat && !last_beat;
            if (last_beat) begin
                beat_cnt <= '0;
            end else if (write_beat) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            // held for one pass, dropped once the last stream cycle is multiplied
            if (last_beat) begin
                full <= 1'b1;
            end else if (rhs_release) begin
                full <= 1'b0;
            end
            rhs_ready <= !full && !write_beat;
        end
    end

    // stored transposed so each PE sees one column of B
    always_ff @(posedge clock) begin
        if (write_beat) begin
            for (int i = 0; i < beat_rows; i++) begin
                for (int c = 0; c < DIM; c++) begin
                    columns[c][int'(beat_cnt) * beat_rows + i] <= rhs_data[i][c];
                end
            end
        end
    end

endmodule

// File: hdl/lhs_sequencer.sv
`timescale 1ns/100ps

module lhs_sequencer (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    lhs_start,
    input  spmm_data_pkg::csr_ptr_t lhs_ptr [spmm_data_pkg::DIM],
    input  logic                    rhs_full,
    input  logic                    out_free,
    output logic                    lhs_ready,
    output logic                    streaming,
    output logic                    last_cycle,
    output logic                    split [spmm_data_pkg::DIM],
    output spmm_data_pkg::lane_t    row_idx [spmm_data_pkg::DIM]
);

    localparam int DIM = spmm_data_pkg::DIM;

    logic                 running;
    spmm_data_pkg::lane_t cycle_cnt;
    logic                 split_table [DIM][DIM];

    // stream cycle 0 is the start cycle itself
    assign streaming = lhs_start | running;
    assign last_cycle = streaming && (cycle_cnt == spmm_data_pkg::lane_t'(DIM - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            running <= 1'b0;
            cycle_cnt <= '0;
        end else begin
            running <= streaming && !last_cycle;
            if (streaming) begin
                cycle_cnt <= cycle_cnt + 1'b1;
            end
        end
    end

    // next pass needs B loaded and room for C
    always_ff @(posedge clock) begin
        if (reset) begin
            lhs_ready <= 1'b0;
        end else begin
            lhs_ready <= rhs_full && out_free && !streaming;
        end
    end

    // one flag per flat position, set where a row ends
    always_comb begin
        for (int c = 0; c < DIM; c++) begin
            for (int k = 0; k < DIM; k++) begin
                split_table[c][k] = 1'b0;
            end
        end
        for (int r = 0; r < DIM; r++) begin
            split_table[lhs_ptr[r].pos.cycle][lhs_ptr[r].pos.lane] = 1'b1;
        end
    end

    // row of a split lane = row ends strictly before its flat position
    always_comb begin
        spmm_data_pkg::csr_ptr_t       pos_k;
        logic [spmm_data_pkg::LG_DIM:0] ends;
        for (int k = 0; k < DIM; k++) begin
            pos_k.pos.cycle = cycle_cnt;
            pos_k.pos.lane = spmm_data_pkg::lane_t'(k);
            ends = '0;
            for (int r = 0; r < DIM; r++) begin
                if (lhs_ptr[r].flat < pos_k.flat) begin
                    ends = ends + 1'b1;
                end
            end
            split[k] = streaming && split_table[cycle_cnt][k];
            row_idx[k] = ends[spmm_data_pkg::LG_DIM-1:0];
        end
    end

endmodule

// File: hdl/segment_reducer.sv
`timescale 1ns/100ps

module segment_reducer (
    input  logic                 clock,
    input  logic                 reset,
    input  spmm_data_pkg::elem_t products [spmm_data_pkg::DIM],
    input  logic                 split [spmm_data_pkg::DIM],
    output spmm_data_pkg::elem_t sums [spmm_data_pkg::DIM]
);

    localparam int DIM = spmm_data_pkg::DIM;
    localparam int LEVELS = spmm_ctrl_pkg::SCAN_LATENCY;

    spmm_data_pkg::elem_t scan [LEVELS+1][DIM];
    logic                 split_d [LEVELS+1][DIM];
    spmm_data_pkg::elem_t seg [DIM];
    spmm_data_pkg::elem_t carry;
    spmm_data_pkg::elem_t carry_next;

    for (genvar k = 0; k < DIM; k++) begin : g_in
        assign scan[0][k] = products[k];
        assign split_d[0][k] = split[k];
    end

    // hillis-steele inclusive scan, one register per level
    for (genvar s = 0; s < LEVELS; s++) begin : g_level
        for (genvar k = 0; k < DIM; k++) begin : g_lane
            if (k >= (1 << s)) begin : g_add
                always_ff @(posedge clock) begin
                    scan[s+1][k] <= scan[s][k] + scan[s][k - (1 << s)];
                end
            end else begin : g_keep
                always_ff @(posedge clock) begin
                    scan[s+1][k] <= scan[s][k];
                end
            end
            always_ff @(posedge clock) begin
                if (reset) begin
                    split_d[s+1][k] <= 1'b0;
                end else begin
                    split_d[s+1][k] <= split_d[s][k];
                end
            end
        end
    end

    // segment sum = prefix here minus prefix at the previous split
    always_comb begin
        spmm_data_pkg::elem_t base;
        logic                 seen;
        base = '0;
        seen = 1'b0;
        for (int k = 0; k < DIM; k++) begin
            seg[k] = scan[LEVELS][k] - base;
            // first row of the cycle picks up what the last cycle left open
            if (!seen) begin
                seg[k] = seg[k] + carry;
            end
            if (split_d[LEVELS][k]) begin
                seen = 1'b1;
                base = scan[LEVELS][k];
            end
        end
        // open tail, zero when the last lane splits
        carry_next = scan[LEVELS][DIM-1] - base;
        if (!seen) begin
            carry_next = carry_next + carry;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            carry <= '0;
        end else begin
            carry <= carry_next;
        end
    end

    always_ff @(posedge clock) begin
        sums <= seg;
    end

endmodule

// File: hdl/spmm_pe.sv
`timescale 1ns/100ps

module spmm_pe (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 streaming,
    input  spmm_data_pkg::lane_t lhs_col [spmm_data_pkg::DIM],
    input  spmm_data_pkg::elem_t lhs_data [spmm_data_pkg::DIM],
    input  spmm_data_pkg::elem_t column [spmm_data_pkg::DIM],
    input  logic                 split [spmm_data_pkg::DIM],
    output spmm_data_pkg::elem_t sums [spmm_data_pkg::DIM]
);

    localparam int DIM = spmm_data_pkg::DIM;
    localparam int MUL_LAT = spmm_ctrl_pkg::MUL_LATENCY;

    spmm_data_pkg::elem_t products [DIM];
    logic                 split_pipe [MUL_LAT][DIM];

    // lane value times the B entry its column selects, zero between passes
    always_ff @(posedge clock) begin
        for (int k = 0; k < DIM; k++) begin
            if (streaming) begin
                products[k] <= spmm_data_pkg::elem_t'(lhs_data[k] * column[lhs_col[k]]);
            end else begin
                products[k] <= '0;
            end
        end
    end

    // split flags follow the products
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MUL_LAT; i++) begin
                for (int k = 0; k < DIM; k++) begin
                    split_pipe[i][k] <= 1'b0;
                end
            end
        end else begin
            split_pipe[0] <= split;
            for (int i = 1; i < MUL_LAT; i++) begin
                split_pipe[i] <= split_pipe[i-1];
            end
        end
    end

    segment_reducer u_reducer (
        .clock    (clock),
        .reset    (reset),
        .products (products),
        .split    (split_pipe[MUL_LAT-1]),
        .sums     (sums)
    );

endmodule

// File: hdl/out_buffer.sv
`timescale 1ns/100ps

module out_buffer #(
    parameter int beat_rows = 4
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 split [spmm_data_pkg::DIM],
    input  spmm_data_pkg::lane_t row_idx [spmm_data_pkg::DIM],
    input  logic                 last_cycle,
    input  spmm_data_pkg::elem_t pe_sums [spmm_data_pkg::DIM][spmm_data_pkg::DIM],
    input  logic                 lhs_start,
    input  logic                 out_start,
    output logic                 out_ready,
    output logic                 out_free,
    output spmm_data_pkg::elem_t out_data [beat_rows][spmm_data_pkg::DIM]
);

    localparam int DIM = spmm_data_pkg::DIM;
    localparam int LAT = spmm_ctrl_pkg::PE_LATENCY;
    localparam int NUM_BEATS = DIM / beat_rows;
    localparam int CNT_W = (NUM_BEATS > 1) ? $clog2(NUM_BEATS) : 1;

    localparam logic [1:0] ST_FREE = 2'd0;
    localparam logic [1:0] ST_FILL = 2'd1;
    localparam logic [1:0] ST_READY = 2'd2;
    localparam logic [1:0] ST_SEND = 2'd3;

    logic                 split_d [LAT][DIM];
    spmm_data_pkg::lane_t row_d [LAT][DIM];
    logic                 last_d [LAT];
    spmm_data_pkg::elem_t c_mem [DIM][DIM];
    logic [1:0]           state;
    logic [CNT_W-1:0]     beat_cnt;
    logic                 sending;
    logic                 last_beat;

    // row metadata waits out the PE pipeline
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < LAT; i++) begin
                last_d[i] <= 1'b0;
                for (int k = 0; k < DIM; k++) begin
                    split_d[i][k] <= 1'b0;
                end
            end
        end else begin
            last_d[0] <= last_cycle;
            split_d[0] <= split;
            for (int i = 1; i < LAT; i++) begin
                last_d[i] <= last_d[i-1];
                split_d[i] <= split_d[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        row_d[0] <= row_idx;
        for (int i = 1; i < LAT; i++) begin
            row_d[i] <= row_d[i-1];
        end
    end

    // a finished row lands in every column at once
    always_ff @(posedge clock) begin
        for (int k = 0; k < DIM; k++) begin
            if (split_d[LAT-1][k]) begin
                for (int j = 0; j < DIM; j++) begin
                    c_mem[row_d[LAT-1][k]][j] <= pe_sums[j][k];
                end
            end
        end
    end

    assign sending = (out_start && state == ST_READY) || state == ST_SEND;
    assign last_beat = sending && (beat_cnt == CNT_W'(NUM_BEATS - 1));
    assign out_free = (state == ST_FREE);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ST_FREE;
            beat_cnt <= '0;
            out_ready <= 1'b0;
        end else begin
            case (state)
                ST_FREE: if (lhs_start) state <= ST_FILL;
                ST_FILL: if (last_d[LAT-1]) state <= ST_READY;
                ST_READY: begin
                    if (last_beat) begin
                        state <= ST_FREE;
                    end else if (out_start) begin
                        state <= ST_SEND;
                    end
                end
                default: if (last_beat) state <= ST_FREE;
            endcase
            if (last_beat) begin
                beat_cnt <= '0;
            end else if (sending) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            out_ready <= (state == ST_READY) && !out_start;
        end
    end

    // beat 0 shows in the out_start cycle
    always_comb begin
        for (int i = 0; i < beat_rows; i++) begin
            for (int j = 0; j < DIM; j++) begin
                out_data[i][j] = sending ? c_mem[int'(beat_cnt) * beat_rows + i][j] : '0;
            end
        end
    end

endmodule

// File: hdl/spmm_top.sv
`timescale 1ns/100ps

module spmm_top #(
    parameter int beat_rows = 4
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    rhs_start,
    input  spmm_data_pkg::elem_t    rhs_data [beat_rows][spmm_data_pkg::DIM],
    output logic                    rhs_ready,
    input  logic                    lhs_start,
    input  spmm_data_pkg::csr_ptr_t lhs_ptr [spmm_data_pkg::DIM],
    input  spmm_data_pkg::lane_t    lhs_col [spmm_data_pkg::DIM],
    input  spmm_data_pkg::elem_t    lhs_data [spmm_data_pkg::DIM],
    output logic                    lhs_ready,
    input  logic                    out_start,
    output logic                    out_ready,
    output spmm_data_pkg::elem_t    out_data [beat_rows][spmm_data_pkg::DIM]
);

    localparam int DIM = spmm_data_pkg::DIM;

    logic                 rhs_full;
    logic                 out_free;
    logic                 streaming;
    logic                 last_cycle;
    logic                 split [DIM];
    spmm_data_pkg::lane_t row_idx [DIM];
    spmm_data_pkg::elem_t columns [DIM][DIM];
    spmm_data_pkg::elem_t pe_sums [DIM][DIM];

    rhs_buffer #(
        .beat_rows (beat_rows)
    ) u_rhs_buffer (
        .clock       (clock),
        .reset       (reset),
        .rhs_start   (rhs_start),
        .rhs_data    (rhs_data),
        .rhs_release (last_cycle),
        .rhs_ready   (rhs_ready),
        .full        (rhs_full),
        .columns     (columns)
    );

    lhs_sequencer u_lhs_sequencer (
        .clock      (clock),
        .reset      (reset),
        .lhs_start  (lhs_start),
        .lhs_ptr    (lhs_ptr),
        .rhs_full   (rhs_full),
        .out_free   (out_free),
        .lhs_ready  (lhs_ready),
        .streaming  (streaming),
        .last_cycle (last_cycle),
        .split      (split),
        .row_idx    (row_idx)
    );

    // one PE per column of B
    for (genvar c = 0; c < DIM; c++) begin : g_pe
        spmm_pe u_pe (
            .clock     (clock),
            .reset     (reset),
            .streaming (streaming),
            .lhs_col   (lhs_col),
            .lhs_data  (lhs_data),
            .column    (columns[c]),
            .split     (split),
            .sums      (pe_sums[c])
        );
    end

    out_buffer #(
        .beat_rows (beat_rows)
    ) u_out_buffer (
        .clock      (clock),
        .reset      (reset),
        .split      (split),
        .row_idx    (row_idx),
        .last_cycle (last_cycle),
        .pe_sums    (pe_sums),
        .lhs_start  (lhs_start),
        .out_start  (out_start),
        .out_ready  (out_ready),
        .out_free   (out_free),
        .out_data   (out_data)
    );

endmodule

// File: verif/spmm_asserts.sv
`timescale 1ns/100ps

module spmm_asserts (
    input logic clock,
    input logic reset,
    input logic rhs_start,
    input logic rhs_ready,
    input logic lhs_start,
    input logic lhs_ready,
    input logic out_start,
    input logic out_ready
);

    // start pulses only while the matching ready is up
    rhs_start_needs_ready: assert property (@(posedge clock) disable iff (reset)
        rhs_start |-> rhs_ready)
        else $error("rhs_start pulsed while rhs_ready was low");

    lhs_start_needs_ready: assert property (@(posedge clock) disable iff (reset)
        lhs_start |-> lhs_ready)
        else $error("lhs_start pulsed while lhs_ready was low");

    out_start_needs_ready: assert property (@(posedge clock) disable iff (reset)
        out_start |-> out_ready)
        else $error("out_start pulsed while out_ready was low");

    // a pass never starts over an unread result
    lhs_out_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(lhs_ready && out_ready))
        else $error("lhs_ready and out_ready high together");

    rhs_lhs_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(rhs_ready && lhs_ready))
        else $error("rhs_ready and lhs_ready high together");

endmodule

// File: verif/spmm_clock_gen.sv
`timescale 1ns/100ps

module spmm_clock_gen #(
    parameter int half_period = 2,
    parameter int reset_cycles = 16
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(half_period) clock = ~clock;
    end

    // released 1 ns after an edge, like every other input
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

// File: verif/spmm_tb.sv
`timescale 1ns/100ps

module spmm_tb;

    localparam int DIM = spmm_data_pkg::DIM;
    localparam int BEAT_ROWS = 4;
    localparam int NUM_BEATS = DIM / BEAT_ROWS;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_JOBS = 9;
    // generous bound on one load, pass and readout
    localparam int CYCLES_PER_JOB = 120;
    localparam int CYCLE_LIMIT = RESET_CYCLES + NUM_JOBS * CYCLES_PER_JOB;
    localparam logic [31:0] SEED = 32'h6467_0b3b;
    // row 2 holds 40 elements across three stream cycles
    localparam int SPAN_PTRS [DIM] = '{5, 20, 60, 70, 90, 100, 130, 150,
                                       170, 180, 200, 210, 230, 240, 250, 255};

    logic                    clock;
    logic                    reset;
    logic                    rhs_start;
    spmm_data_pkg::elem_t    rhs_data [BEAT_ROWS][DIM];
    logic                    rhs_ready;
    logic                    lhs_start;
    spmm_data_pkg::csr_ptr_t lhs_ptr [DIM];
    spmm_data_pkg::lane_t    lhs_col [DIM];
    spmm_data_pkg::elem_t    lhs_data [DIM];
    logic                    lhs_ready;
    logic                    out_start;
    logic                    out_ready;
    spmm_data_pkg::elem_t    out_data [BEAT_ROWS][DIM];

    int                   ptr_mem [NUM_JOBS][DIM];
    spmm_data_pkg::lane_t col_mem [NUM_JOBS][DIM*DIM];
    spmm_data_pkg::elem_t val_mem [NUM_JOBS][DIM*DIM];
    spmm_data_pkg::elem_t b_mem [NUM_JOBS][DIM][DIM];
    spmm_data_pkg::elem_t expected_c [NUM_JOBS][DIM][DIM];
    int                   jobs_checked = 0;
    int                   cycle_count = 0;

    spmm_clock_gen #(
        .reset_cycles (RESET_CYCLES)
    ) u_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    spmm_top #(
        .beat_rows (BEAT_ROWS)
    ) u_dut (
        .clock     (clock),
        .reset     (reset),
        .rhs_start (rhs_start),
        .rhs_data  (rhs_data),
        .rhs_ready (rhs_ready),
        .lhs_start (lhs_start),
        .lhs_ptr   (lhs_ptr),
        .lhs_col   (lhs_col),
        .lhs_data  (lhs_data),
        .lhs_ready (lhs_ready),
        .out_start (out_start),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    bind spmm_top spmm_asserts u_asserts (
        .clock     (clock),
        .reset     (reset),
        .rhs_start (rhs_start),
        .rhs_ready (rhs_ready),
        .lhs_start (lhs_start),
        .lhs_ready (lhs_ready),
        .out_start (out_start),
        .out_ready (out_ready)
    );

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "first mismatch, run stopped");
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    function automatic void build_job(input int job);
        logic chosen [DIM*DIM];
        int   count;
        int   p;
        int   r;
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                b_mem[job][i][j] = spmm_data_pkg::elem_t'($urandom);
            end
        end
        for (int q = 0; q < DIM*DIM; q++) begin
            col_mem[job][q] = spmm_data_pkg::lane_t'($urandom);
            val_mem[job][q] = spmm_data_pkg::elem_t'($urandom);
            chosen[q] = 1'b0;
        end
        case (job)
            0: begin
                for (int i = 0; i < DIM; i++) begin
                    ptr_mem[job][i] = i * DIM + DIM - 1;
                end
            end
            1: begin
                for (int i = 0; i < DIM; i++) begin
                    ptr_mem[job][i] = SPAN_PTRS[i];
                end
            end
            2: begin
                // single rows at the start of cycle 2 and one long row after them
                ptr_mem[job][0] = 31;
                for (int i = 1; i < DIM - 1; i++) begin
                    ptr_mem[job][i] = 31 + i;
                end
                ptr_mem[job][DIM-1] = DIM * DIM - 1;
                // pairs that cancel mod 256 so the long row sums to zero
                for (int q = 46; q < DIM*DIM; q += 2) begin
                    col_mem[job][q+1] = col_mem[job][q];
                    val_mem[job][q+1] = -val_mem[job][q];
                end
            end
            default: begin
                count = 0;
                while (count < DIM - 1) begin
                    p = $urandom % (DIM * DIM - 1);
                    if (!chosen[p]) begin
                        chosen[p] = 1'b1;
                        count++;
                    end
                end
                r = 0;
                for (int q = 0; q < DIM*DIM - 1; q++) begin
                    if (chosen[q]) begin
                        ptr_mem[job][r] = q;
                        r++;
                    end
                end
                ptr_mem[job][DIM-1] = DIM * DIM - 1;
            end
        endcase
    endfunction

    // every flat position belongs to the row whose end pointer it reaches first
    function automatic void compute_expected(input int job);
        int                   row;
        spmm_data_pkg::elem_t prod;
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                expected_c[job][i][j] = '0;
            end
        end
        row = 0;
        for (int p = 0; p < DIM*DIM; p++) begin
            for (int j = 0; j < DIM; j++) begin
                prod = spmm_data_pkg::elem_t'(val_mem[job][p] * b_mem[job][col_mem[job][p]][j]);
                expected_c[job][row][j] = expected_c[job][row][j] + prod;
            end
            if (row < DIM - 1 && p == ptr_mem[job][row]) begin
                row++;
            end
        end
    endfunction

    task automatic load_b(input int job);
        while (!rhs_ready) next_cycle();
        for (int b = 0; b < NUM_BEATS; b++) begin
            rhs_start = (b == 0);
            for (int i = 0; i < BEAT_ROWS; i++) begin
                for (int c = 0; c < DIM; c++) begin
                    rhs_data[i][c] = b_mem[job][b * BEAT_ROWS + i][c];
                end
            end
            next_cycle();
        end
        rhs_start = 1'b0;
        for (int i = 0; i < BEAT_ROWS; i++) begin
            for (int c = 0; c < DIM; c++) begin
                rhs_data[i][c] = '0;
            end
        end
    endtask

    task automatic stream_a(input int job);
        while (!lhs_ready) next_cycle();
        // earlier results must be fully read before a new pass
        check_equal(jobs_checked, job, "jobs read out when lhs_ready rose");
        for (int r = 0; r < DIM; r++) begin
            lhs_ptr[r].flat = ptr_mem[job][r][2*spmm_data_pkg::LG_DIM-1:0];
        end
        for (int c = 0; c < DIM; c++) begin
            lhs_start = (c == 0);
            for (int k = 0; k < DIM; k++) begin
                lhs_col[k] = col_mem[job][c * DIM + k];
                lhs_data[k] = val_mem[job][c * DIM + k];
            end
            next_cycle();
        end
        lhs_start = 1'b0;
        for (int k = 0; k < DIM; k++) begin
            lhs_col[k] = '0;
            lhs_data[k] = '0;
        end
    endtask

    task automatic read_c();
        while (!out_ready) next_cycle();
        out_start = 1'b1;
        next_cycle();
        out_start = 1'b0;
    endtask

    initial begin : run_tests
        rhs_start = 1'b0;
        lhs_start = 1'b0;
        out_start = 1'b0;
        for (int i = 0; i < BEAT_ROWS; i++) begin
            for (int c = 0; c < DIM; c++) begin
                rhs_data[i][c] = '0;
            end
        end
        for (int k = 0; k < DIM; k++) begin
            lhs_ptr[k] = '0;
            lhs_col[k] = '0;
            lhs_data[k] = '0;
        end
        void'($urandom(SEED));
        for (int j = 0; j < NUM_JOBS; j++) begin
            build_job(j);
            compute_expected(j);
        end

        next_cycle();
        wait (!reset);
        // first edge with reset low loads the ready levels
        next_cycle();
        check_equal(rhs_ready, 1, "rhs_ready after reset");
        check_equal(lhs_ready, 0, "lhs_ready after reset");
        check_equal(out_ready, 0, "out_ready after reset");

        load_b(0);
        while (!lhs_ready) next_cycle();
        check_equal(rhs_ready, 0, "rhs_ready with B loaded");
        check_equal(out_ready, 0, "out_ready before any pass");

        for (int j = 0; j < NUM_JOBS; j++) begin
            stream_a(j);
            if (j + 1 < NUM_JOBS) begin
                // next B goes in while this C waits
                load_b(j + 1);
                while (!out_ready) next_cycle();
                check_equal(lhs_ready, 0, "lhs_ready with C pending");
                check_equal(rhs_ready, 0, "rhs_ready with next B held");
            end
            read_c();
        end
        repeat (NUM_BEATS + 2) next_cycle();

        if (jobs_checked == NUM_JOBS) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Only %0d of %0d results were read out", jobs_checked, NUM_JOBS);
            $display("Testbench failed");
            $fatal(1, "missing results");
        end
    end

    // sampled mid-cycle when inputs and registers have settled
    initial begin : compare_output
        int beat;
        beat = 0;
        forever begin
            @(negedge clock);
            if (reset) begin
                beat = 0;
            end else if (out_start || beat != 0) begin
                for (int i = 0; i < BEAT_ROWS; i++) begin
                    for (int j = 0; j < DIM; j++) begin
                        check_equal(out_data[i][j],
                                    expected_c[jobs_checked][beat * BEAT_ROWS + i][j],
                                    $sformatf("job %0d C[%0d][%0d]", jobs_checked,
                                              beat * BEAT_ROWS + i, j));
                    end
                end
                beat++;
                if (beat == NUM_BEATS) begin
                    beat = 0;
                    jobs_checked++;
                end
            end else begin
                for (int i = 0; i < BEAT_ROWS; i++) begin
                    for (int j = 0; j < DIM; j++) begin
                        check_equal(out_data[i][j], 0, "out_data outside readout");
                    end
                end
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $fatal(1, "cycle limit reached");
        end
    end

endmodule

// File: sources.f
hdl/spmm_data_pkg.sv
hdl/spmm_ctrl_pkg.sv
hdl/rhs_buffer.sv
hdl/lhs_sequencer.sv
hdl/segment_reducer.sv
hdl/spmm_pe.sv
hdl/out_buffer.sv
hdl/spmm_top.sv
verif/spmm_asserts.sv
verif/spmm_clock_gen.sv
verif/spmm_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
TOP       ?= spmm_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
